// File: clk_enables.sv
`timescale 1ns/1ps

module clk_enables #(
	parameter int SOUND_DIV = 45
) (
	input  logic clk_sys,
	input  logic rst_n,
	output logic cpu_clk,
	output logic cen_5,
	output logic cen_10_p,
	output logic cen_10_n,
	output logic sound_cen
);

	localparam int SND_W = (SOUND_DIV > 1) ? $clog2(SOUND_DIV) : 1;

	logic [2:0] phase;
	logic [SND_W-1:0] snd_cnt;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			phase <= '0;
			cpu_clk <= 1'b0;
			cen_5 <= 1'b0;
			cen_10_p <= 1'b0;
			cen_10_n <= 1'b0;
		end else begin
			phase <= phase + 3'd1; // wraps at 7
			cpu_clk <= phase[2];
			cen_5 <= phase == 3'd7;
			cen_10_p <= phase == 3'd3 || phase == 3'd7;
			cen_10_n <= phase == 3'd1 || phase == 3'd5;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			snd_cnt <= '0;
			sound_cen <= 1'b0;
		end else begin
			sound_cen <= snd_cnt == SND_W'(SOUND_DIV - 1);
			snd_cnt <= (snd_cnt == SND_W'(SOUND_DIV - 1)) ? '0 : snd_cnt + 1'b1;
		end
	end

	a_cen10_excl: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(cen_10_p && cen_10_n));

endmodule

// File: download_ctrl.sv
`timescale 1ns/1ps

module download_ctrl (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic ioctl_download,
	input  logic [7:0] ioctl_index,
	input  logic ioctl_wr,
	input  logic [24:0] ioctl_addr,
	input  logic [7:0] ioctl_dout,
	input  logic reset_req,
	input  logic button_reset,
	output logic prog_wr_valid,
	output qbert_shell_pkg::prog_wr_t prog_wr,
	output logic gfx_wr_valid,
	output qbert_shell_pkg::gfx_wr_t gfx_wr,
	output logic rom_loaded,
	output logic core_reset
);

	import qbert_shell_pkg::*;

	logic wr_d;
	logic wr_hit;
	logic [24:0] addr_q;
	logic [7:0] dout_q;
	logic is_gfx;
	logic [24:0] gfx_off;
	logic dl_rom_d;
	logic dl_done;

	// stage 1: edge of the write strobe during a ROM download
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			wr_d <= 1'b0;
			wr_hit <= 1'b0;
		end else begin
			wr_d <= ioctl_wr;
			wr_hit <= ioctl_wr && !wr_d && ioctl_download && ioctl_index == ROM_INDEX;
		end
	end

	always_ff @(posedge clk_sys) begin
		addr_q <= ioctl_addr;
		dout_q <= ioctl_dout;
	end

	assign is_gfx = addr_q >= GFX_BASE;
	assign gfx_off = addr_q - GFX_BASE;

	// stage 2: port select and address mapping
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			prog_wr_valid <= 1'b0;
			gfx_wr_valid <= 1'b0;
		end else begin
			prog_wr_valid <= wr_hit && !is_gfx;
			gfx_wr_valid <= wr_hit && is_gfx;
		end
	end

	always_ff @(posedge clk_sys) begin
		prog_wr.addr <= addr_q[23:1];
		prog_wr.ds <= {addr_q[0], ~addr_q[0]};
		prog_wr.data <= {dout_q, dout_q};
		gfx_wr.addr <= {gfx_off[13:0], gfx_off[15]}; // two roms side by side in one word
		gfx_wr.ds <= {gfx_off[14], ~gfx_off[14]};
		gfx_wr.data <= {dout_q, dout_q};
	end

	// end of a ROM download releases the core
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			dl_rom_d <= 1'b0;
			dl_done <= 1'b0;
			rom_loaded <= 1'b0;
			core_reset <= 1'b1;
		end else begin
			dl_rom_d <= ioctl_download && ioctl_index == ROM_INDEX;
			dl_done <= dl_rom_d && !ioctl_download;
			if (dl_done)
				rom_loaded <= 1'b1;
			core_reset <= reset_req | button_reset | ~rom_loaded;
		end
	end

endmodule

// File: input_map.sv
`timescale 1ns/1ps

module input_map (
	input  logic clk_sys,
	input  logic rst_n,
	input  qbert_shell_pkg::core_mod_e core_mod,
	input  logic diagonal,
	input  logic service,
	input  qbert_shell_pkg::player_t p1,
	input  qbert_shell_pkg::player_t p2,
	input  qbert_shell_pkg::cab_ctrl_t ctrl,
	output qbert_shell_pkg::cab_in_t cab_in
);

	import qbert_shell_pkg::*;

	logic [7:0] joy_plain;
	logic [7:0] joy_diag;
	logic [7:0] joy4;
	cab_in_t cab_nxt;

	assign joy_plain = {
		p2.down, p2.up, p2.left, p2.right,
		p1.down, p1.up, p1.left, p1.right
	};

	// 45 degree rotated sticks
	assign joy_diag = {
		p2.down & p2.left,
		p2.up & p2.right,
		p2.left & p2.up,
		p2.right & p2.down,
		p1.down & p1.left,
		p1.up & p1.right,
		p1.left & p1.up,
		p1.right & p1.down
	};

	assign joy4 = diagonal ? joy_diag : joy_plain;

	always_comb begin
		cab_nxt.in1 = {p1.fire_a, ~service, 2'b00, ctrl.coin2, ctrl.coin1,
			ctrl.start2, ctrl.start1};
		cab_nxt.in4 = joy4;

		case (core_mod)
			mod_mplanets: begin
				cab_nxt.in1 = {~service, p1.fire_a, 4'd0, ctrl.coin2, ctrl.coin1};
				cab_nxt.in4 = {
					p1.fire_b,
					ctrl.start2,
					ctrl.start1,
					p1.fire_a,
					p1.left,
					p1.down,
					p1.right,
					p1.up
				};
			end
			mod_krull: begin
				cab_nxt.in1 = {ctrl.start2, ctrl.start1, 2'b00, ctrl.coin2, ctrl.coin1,
					p1.fire_a, ~service};
				cab_nxt.in4 = {
					p1.left, // move stick
					p1.down,
					p1.right,
					p1.up,
					p2.left | p1.left_b, // fire stick
					p2.down | p1.down_b,
					p2.right | p1.right_b,
					p2.up | p1.up_b
				};
			end
			mod_curvebal: begin
				cab_nxt.in1 = {4'd0, ctrl.coin2, ctrl.coin1, p1.fire_a, ~service};
				cab_nxt.in4 = {
					1'b0,
					p1.fire_d | p1.down, // bunt
					1'b0,
					p1.fire_c | p1.right, // pitch right
					1'b0,
					p1.fire_b | p1.left, // pitch left
					p1.fire_a | p1.up, // swing
					1'b0
				};
			end
			mod_tylz: begin
				cab_nxt.in1 = {4'd0, ctrl.coin1, ctrl.coin2, p1.fire_a, ~service};
				cab_nxt.in4 = {
					1'b0,
					ctrl.start2,
					ctrl.start1,
					p1.fire_a,
					diagonal ? p1.left & p1.up : p1.left,
					diagonal ? p1.right & p1.up : p1.up,
					diagonal ? p1.right & p1.down : p1.right,
					diagonal ? p1.left & p1.down : p1.down
				};
			end
			mod_insector: begin
				cab_nxt.in1 = {1'b0, ~service, p2.fire_b, p2.fire_a, ctrl.coin2, ctrl.coin1,
					p1.fire_b, p1.fire_a};
				cab_nxt.in4 = {
					p2.left,
					p2.down,
					p2.right,
					p2.up,
					p1.left,
					p1.down,
					p1.right,
					p1.up
				};
			end
			default: begin
				// qbert and qub keep the base layout
			end
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			cab_in <= '0;
		else
			cab_in <= cab_nxt;
	end

endmodule

// File: qbert_shell.f
qbert_shell_pkg.sv
clk_enables.sv
input_map.sv
rom_port_writer.sv
download_ctrl.sv
qbert_shell_top.sv
tb_qbert_shell.sv

// File: qbert_shell_pkg.sv
package qbert_shell_pkg;

	localparam int PROG_ADDR_W = 23; // 16-bit words
	localparam int GFX_ADDR_W = 15;

	// graphics ROMs start here in the download stream
	localparam logic [24:0] GFX_BASE = 25'h10000;
	localparam logic [7:0] ROM_INDEX = 8'd0;

	// option word as sent by the menu
	typedef struct packed {
		logic reset_req;
		logic pause;
		logic rotate;
		logic [1:0] scanlines;
		logic blend;
		logic joyswap;
		logic flip;
		logic service; // test mode
		logic diagonal;
		logic [7:0] dip_sw;
	} status_t;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire_a;
		logic fire_b;
		logic fire_c;
		logic fire_d;
		logic up_b; // second stick
		logic down_b;
		logic left_b;
		logic right_b;
	} player_t;

	typedef struct packed {
		logic coin1;
		logic coin2;
		logic start1;
		logic start2;
	} cab_ctrl_t;

	typedef struct packed {
		logic [7:0] in1; // port 1710
		logic [7:0] in4; // port 4740
	} cab_in_t;

	typedef struct packed {
		logic [PROG_ADDR_W-1:0] addr;
		logic [1:0] ds; // {upper, lower}
		logic [15:0] data;
	} prog_wr_t;

	typedef struct packed {
		logic [GFX_ADDR_W-1:0] addr;
		logic [1:0] ds;
		logic [15:0] data;
	} gfx_wr_t;

	// Gottlieb/Mylstar game variants, as reported in core_mod
	typedef enum logic [6:0] {
		mod_qbert = 7'd0,
		mod_qub = 7'd1,
		mod_mplanets = 7'd2,
		mod_krull = 7'd3,
		mod_curvebal = 7'd4,
		mod_tylz = 7'd5,
		mod_insector = 7'd6
	} core_mod_e;

endpackage

// File: qbert_shell_top.sv
`timescale 1ns/1ps

module qbert_shell_top #(
	parameter int SOUND_DIV = 45
) (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic [31:0] status_raw,
	input  logic button_reset,
	input  qbert_shell_pkg::player_t joystick_0,
	input  qbert_shell_pkg::player_t joystick_1,
	input  qbert_shell_pkg::cab_ctrl_t controls,
	input  qbert_shell_pkg::core_mod_e core_mod,
	input  logic ioctl_download,
	input  logic [7:0] ioctl_index,
	input  logic ioctl_wr,
	input  logic [24:0] ioctl_addr,
	input  logic [7:0] ioctl_dout,
	output logic prog_req,
	input  logic prog_ack,
	output qbert_shell_pkg::prog_wr_t prog_cmd,
	output logic gfx_req,
	input  logic gfx_ack,
	output qbert_shell_pkg::gfx_wr_t gfx_cmd,
	output qbert_shell_pkg::cab_in_t cab_in,
	output logic cpu_clk,
	output logic cen_5,
	output logic cen_10_p,
	output logic cen_10_n,
	output logic sound_cen,
	output logic core_reset,
	output logic rom_loaded,
	output logic flip,
	output logic pause
);

	import qbert_shell_pkg::*;

	status_t status;
	logic prog_wr_valid;
	prog_wr_t prog_wr;
	logic gfx_wr_valid;
	gfx_wr_t gfx_wr;

	// menu option bit positions
	assign status.reset_req = status_raw[0];
	assign status.pause = status_raw[1];
	assign status.rotate = status_raw[2];
	assign status.scanlines = status_raw[4:3];
	assign status.blend = status_raw[5];
	assign status.joyswap = status_raw[6];
	assign status.flip = status_raw[7];
	assign status.service = status_raw[8];
	assign status.diagonal = status_raw[9];
	assign status.dip_sw = status_raw[23:16];

	assign flip = status.flip;
	assign pause = status.pause;

	clk_enables #(.SOUND_DIV(SOUND_DIV)) clk_enables_inst (
		.clk_sys(clk_sys), .rst_n(rst_n), .cpu_clk(cpu_clk), .cen_5(cen_5),
		.cen_10_p(cen_10_p), .cen_10_n(cen_10_n), .sound_cen(sound_cen)
	);

	input_map input_map_inst (
		.clk_sys(clk_sys), .rst_n(rst_n), .core_mod(core_mod),
		.diagonal(status.diagonal), .service(status.service),
		.p1(joystick_0), .p2(joystick_1), .ctrl(controls), .cab_in(cab_in)
	);

	download_ctrl download_ctrl_inst (
		.clk_sys(clk_sys), .rst_n(rst_n), .ioctl_download(ioctl_download),
		.ioctl_index(ioctl_index), .ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout), .reset_req(status.reset_req),
		.button_reset(button_reset), .prog_wr_valid(prog_wr_valid), .prog_wr(prog_wr),
		.gfx_wr_valid(gfx_wr_valid), .gfx_wr(gfx_wr), .rom_loaded(rom_loaded),
		.core_reset(core_reset)
	);

	rom_port_writer #(.payload_t(prog_wr_t)) prog_writer (
		.clk_sys(clk_sys), .rst_n(rst_n), .wr_valid(prog_wr_valid), .wr_cmd(prog_wr),
		.req(prog_req), .ack(prog_ack), .cmd(prog_cmd), .busy()
	);

	rom_port_writer #(.payload_t(gfx_wr_t)) gfx_writer (
		.clk_sys(clk_sys), .rst_n(rst_n), .wr_valid(gfx_wr_valid), .wr_cmd(gfx_wr),
		.req(gfx_req), .ack(gfx_ack), .cmd(gfx_cmd), .busy()
	);

endmodule

// File: rom_port_writer.sv
`timescale 1ns/1ps

module rom_port_writer #(
	parameter type payload_t = logic
) (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic wr_valid,
	input  payload_t wr_cmd,
	output logic req,
	input  logic ack,
	output payload_t cmd,
	output logic busy
);

	logic accept;

	// toggle protocol: pending while req and ack differ
	assign busy = req ^ ack;
	assign accept = wr_valid && !busy;

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			req <= 1'b0;
		else if (accept)
			req <= ~req;
	end

	// payload only, held for the memory side
	always_ff @(posedge clk_sys) begin
		if (accept)
			cmd <= wr_cmd;
	end

	// download is paced far below the memory turnaround
	a_no_overrun: assert property (@(posedge clk_sys) disable iff (!rst_n)
		wr_valid |-> !busy);

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the shell testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_qbert_shell -f qbert_shell.f -o sim_qbert_shell

./obj_dir/sim_qbert_shell > sim.log 2>&1 || true
cat sim.log

if grep -q "^ALL TESTS PASSED$" sim.log; then
	exit 0
fi
echo "simulation did not pass"
exit 1

// File: tb_qbert_shell.sv
`timescale 1ns/1ps

module tb_qbert_shell;

	import qbert_shell_pkg::*;

	localparam int SOUND_DIV = 45;
	localparam int N_PROG = 12;
	localparam int N_GFX = 12;
	localparam int N_MAP = 6;
	localparam int CEN_CYCLES = 3 * SOUND_DIV + 8;
	localparam int WRITE_CYCLES = 25; // worst case per byte incl. ack
	localparam int TEST_CYCLES = CEN_CYCLES + (N_PROG + N_GFX + 8) * WRITE_CYCLES
		+ 14 * N_MAP * 2 + 60;
	localparam int PORT_NONE = 0;
	localparam int PORT_PROG = 1;
	localparam int PORT_GFX = 2;

	logic clk_sys;
	logic rst_n;
	logic [31:0] status_raw;
	logic button_reset;
	player_t joystick_0;
	player_t joystick_1;
	cab_ctrl_t controls;
	core_mod_e core_mod;
	logic ioctl_download;
	logic [7:0] ioctl_index;
	logic ioctl_wr;
	logic [24:0] ioctl_addr;
	logic [7:0] ioctl_dout;
	logic prog_req;
	logic prog_ack;
	prog_wr_t prog_cmd;
	logic gfx_req;
	logic gfx_ack;
	gfx_wr_t gfx_cmd;
	cab_in_t cab_in;
	logic cpu_clk;
	logic cen_5;
	logic cen_10_p;
	logic cen_10_n;
	logic sound_cen;
	logic core_reset;
	logic rom_loaded;
	logic flip;
	logic pause;
	int errors = 0;
	int seed_ret;

	qbert_shell_top #(.SOUND_DIV(SOUND_DIV)) qbert_shell_top_inst (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %0h expected %0h", name, got, exp);
			errors++;
		end
	endtask

	// memory side of the toggle handshake, random latency
	initial begin
		int unsigned lat;
		prog_ack = 1'b0;
		forever begin
			@(posedge clk_sys);
			if (prog_req != prog_ack) begin
				lat = $urandom_range(0, 5);
				repeat (lat) @(posedge clk_sys);
				prog_ack <= prog_req;
			end
		end
	end

	initial begin
		int unsigned lat;
		gfx_ack = 1'b0;
		forever begin
			@(posedge clk_sys);
			if (gfx_req != gfx_ack) begin
				lat = $urandom_range(0, 5);
				repeat (lat) @(posedge clk_sys);
				gfx_ack <= gfx_req;
			end
		end
	end

	function automatic cab_in_t model_cab(core_mod_e m, logic dg, logic svc, player_t a,
		player_t b, cab_ctrl_t c);
		cab_in_t r;
		logic [3:0] s1;
		logic [3:0] s2;
		s1 = {a.down, a.up, a.left, a.right};
		s2 = {b.down, b.up, b.left, b.right};
		if (dg) begin // rotated sticks
			s1 = {a.down & a.left, a.up & a.right, a.left & a.up, a.right & a.down};
			s2 = {b.down & b.left, b.up & b.right, b.left & b.up, b.right & b.down};
		end
		r.in1 = {a.fire_a, ~svc, 2'b00, c.coin2, c.coin1, c.start2, c.start1};
		r.in4 = {s2, s1};
		case (m)
			mod_mplanets: begin
				r.in1 = {~svc, a.fire_a, 4'h0, c.coin2, c.coin1};
				r.in4 = {a.fire_b, c.start2, c.start1, a.fire_a, a.left, a.down, a.right, a.up};
			end
			mod_krull: begin
				r.in1 = {c.start2, c.start1, 2'b00, c.coin2, c.coin1, a.fire_a, ~svc};
				r.in4 = {a.left, a.down, a.right, a.up, b.left | a.left_b,
					b.down | a.down_b, b.right | a.right_b, b.up | a.up_b};
			end
			mod_curvebal: begin
				r.in1 = {4'h0, c.coin2, c.coin1, a.fire_a, ~svc};
				r.in4 = {1'b0, a.fire_d | a.down, 1'b0, a.fire_c | a.right, 1'b0,
					a.fire_b | a.left, a.fire_a | a.up, 1'b0};
			end
			mod_tylz: begin
				r.in1 = {4'h0, c.coin1, c.coin2, a.fire_a, ~svc};
				r.in4 = {1'b0, c.start2, c.start1, a.fire_a, 4'h0};
				r.in4[3:0] = dg ? {a.left & a.up, a.right & a.up, a.right & a.down, a.left & a.down}
					: {a.left, a.up, a.right, a.down};
			end
			mod_insector: begin
				r.in1 = {1'b0, ~svc, b.fire_b, b.fire_a, c.coin2, c.coin1, a.fire_b, a.fire_a};
				r.in4 = {b.left, b.down, b.right, b.up, a.left, a.down, a.right, a.up};
			end
			default: ;
		endcase
		return r;
	endfunction

	// one download byte, then follow the port it should reach
	task automatic rom_write(input logic [24:0] addr, input logic [7:0] data, input int port);
		logic prog_old;
		logic gfx_old;
		logic [24:0] off;
		int t;
		prog_old = prog_req;
		gfx_old = gfx_req;
		off = addr - 25'h10000;
		@(posedge clk_sys);
		ioctl_addr <= addr;
		ioctl_dout <= data;
		ioctl_wr <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		t = 0;
		while (prog_req == prog_old && gfx_req == gfx_old && t < 8) begin
			@(negedge clk_sys);
			t++;
		end
		if (port == PORT_NONE) begin
			check("prog_req", prog_req, prog_old);
			check("gfx_req", gfx_req, gfx_old);
		end else if (t == 8) begin
			$display("no request toggle seen for download address %h", addr);
			errors++;
		end else if (port == PORT_PROG) begin
			check("gfx_req", gfx_req, gfx_old);
			check("prog_cmd.addr", prog_cmd.addr, addr[23:1]);
			check("prog_cmd.ds", prog_cmd.ds, addr[0] ? 2'b10 : 2'b01);
			check("prog_cmd.data", prog_cmd.data, {data, data});
		end else begin
			check("prog_req", prog_req, prog_old);
			check("gfx_cmd.addr", gfx_cmd.addr, {off[13:0], off[15]});
			check("gfx_cmd.ds", gfx_cmd.ds, off[14] ? 2'b10 : 2'b01);
			check("gfx_cmd.data", gfx_cmd.data, {data, data});
		end
		t = 0;
		while ((prog_ack != prog_req || gfx_ack != gfx_req) && t < 12) begin
			@(negedge clk_sys);
			t++;
		end
		if (t == 12) begin
			$display("memory acknowledge never caught up with the request");
			errors++;
		end
	endtask

	task automatic measure_clk_enables();
		int last5;
		int last_snd;
		int last_cpu;
		logic cpu_prev;
		int n_p;
		int n_n;
		last5 = -1;
		last_snd = -1;
		last_cpu = -1;
		cpu_prev = cpu_clk;
		n_p = 0;
		n_n = 0;
		for (int i = 0; i < CEN_CYCLES; i++) begin
			@(negedge clk_sys);
			check("cen_10_p & cen_10_n", cen_10_p & cen_10_n, 0);
			n_p += int'(cen_10_p);
			n_n += int'(cen_10_n);
			if (cen_5) begin
				if (last5 >= 0) begin
					check("cen_5 spacing", i - last5, 8);
					check("cen_10_p per 8", n_p, 2);
					check("cen_10_n per 8", n_n, 2);
				end
				last5 = i;
				n_p = 0;
				n_n = 0;
			end
			if (sound_cen) begin
				if (last_snd >= 0)
					check("sound_cen spacing", i - last_snd, SOUND_DIV);
				last_snd = i;
			end
			if (cpu_clk != cpu_prev) begin // half of an 8 cycle square wave
				if (last_cpu >= 0)
					check("cpu_clk half period", i - last_cpu, 4);
				last_cpu = i;
			end
			cpu_prev = cpu_clk;
		end
		if (last5 < 0 || last_snd < 0 || last_cpu < 0) begin
			$display("clock enables never pulsed");
			errors++;
		end
	endtask

	task automatic drive_prog_writes();
		check("core_reset", core_reset, 1);
		rom_write(25'h0, 8'h5a, PORT_PROG);
		rom_write(25'h1, 8'ha5, PORT_PROG);
		rom_write(25'h0ffff, 8'h3c, PORT_PROG); // last byte below the graphics area
		for (int k = 0; k < N_PROG; k++)
			rom_write(25'($urandom_range(0, 16'hffff)), 8'($urandom), PORT_PROG);
	endtask

	task automatic drive_gfx_writes();
		rom_write(25'h10000, 8'h11, PORT_GFX);
		rom_write(25'h14000, 8'h22, PORT_GFX);
		rom_write(25'h18000, 8'h33, PORT_GFX);
		rom_write(25'h1ffff, 8'h44, PORT_GFX);
		for (int k = 0; k < N_GFX; k++)
			rom_write(25'h10000 + 25'($urandom_range(0, 16'hffff)), 8'($urandom), PORT_GFX);
		@(posedge clk_sys);
		ioctl_index <= 8'd1;
		rom_write(25'h00123, 8'h77, PORT_NONE);
		rom_write(25'h12345, 8'h88, PORT_NONE);
		@(posedge clk_sys);
		ioctl_index <= 8'd0;
	endtask

	task automatic hold_reset_source(input bit use_button);
		@(posedge clk_sys);
		if (use_button)
			button_reset <= 1'b1;
		else
			status_raw[0] <= 1'b1;
		repeat (4) begin
			@(posedge clk_sys);
			@(negedge clk_sys);
			check("core_reset", core_reset, 1);
		end
		@(posedge clk_sys);
		button_reset <= 1'b0;
		status_raw[0] <= 1'b0;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check("core_reset", core_reset, 0);
	endtask

	task automatic release_after_load();
		check("core_reset", core_reset, 1);
		check("rom_loaded", rom_loaded, 0);
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check("rom_loaded", rom_loaded, 0);
		@(negedge clk_sys);
		check("rom_loaded", rom_loaded, 1);
		@(negedge clk_sys);
		check("core_reset", core_reset, 0);
		hold_reset_source(1'b0);
		hold_reset_source(1'b1);
	endtask

	task automatic sweep_input_map();
		player_t a;
		player_t b;
		cab_ctrl_t c;
		logic svc;
		logic fl;
		logic pa;
		cab_in_t exp;
		for (int m = 0; m < 7; m++) begin
			for (int dg = 0; dg < 2; dg++) begin
				for (int k = 0; k < N_MAP; k++) begin
					a = player_t'(12'($urandom));
					b = player_t'(12'($urandom));
					c = cab_ctrl_t'(4'($urandom));
					svc = 1'($urandom);
					fl = 1'($urandom);
					pa = 1'($urandom);
					@(posedge clk_sys);
					core_mod <= core_mod_e'(m);
					joystick_0 <= a;
					joystick_1 <= b;
					controls <= c;
					status_raw[9:8] <= {dg[0], svc};
					status_raw[7] <= fl;
					status_raw[1] <= pa;
					@(posedge clk_sys);
					@(negedge clk_sys);
					exp = model_cab(core_mod_e'(m), dg[0], svc, a, b, c);
					check("cab_in.in1", cab_in.in1, exp.in1);
					check("cab_in.in4", cab_in.in4, exp.in4);
					check("flip", flip, fl);
					check("pause", pause, pa);
				end
			end
		end
	endtask

	initial begin
		repeat (TEST_CYCLES + 200) @(posedge clk_sys);
		$display("watchdog expired before the tests completed");
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		seed_ret = $urandom(32'h875e_2869);
		rst_n = 1'b0;
		status_raw = '0;
		button_reset = 1'b0;
		joystick_0 = '0;
		joystick_1 = '0;
		controls = '0;
		core_mod = mod_qbert;
		ioctl_download = 1'b0;
		ioctl_index = 8'd0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		check("cen_5 in reset", cen_5, 0);
		check("core_reset in reset", core_reset, 1);
		@(posedge clk_sys);
		rst_n <= 1'b1;
		@(negedge clk_sys);
		check("rom_loaded", rom_loaded, 0);
		check("prog_req", prog_req, 0);
		check("gfx_req", gfx_req, 0);
		measure_clk_enables();
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		drive_prog_writes();
		drive_gfx_writes();
		release_after_load();
		sweep_input_map();
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule
